/* tb.f */
src/mem_pkg.sv
src/bus_pkg.sv
src/sram_bank.sv
src/mem_arbiter.sv
src/ahb_sram_port.sv
src/apb_mem_port.sv
src/sram_subsys_top.sv
dv/sram_subsys_asserts.sv
dv/tb_sram_subsys.sv

/* dv/tb_sram_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sram_subsys;

    import mem_pkg::*;
    import bus_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles allowed per wait loop

    logic      clk;
    logic      rst_n;
    logic      hsel;
    logic      hwrite;
    logic      hready;
    bus_addr_t haddr;
    logic [1:0] htrans;
    logic [2:0] hsize;
    mem_word_t hwdata;
    byte_en_t  hwstrb;
    logic      hready_out;
    mem_word_t hrdata;
    logic      hresp;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_off_t  paddr;
    mem_word_t pwdata;
    mem_word_t prdata;
    logic      pready;
    logic      pslverr;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    mem_word_t   ref_mem [MEM_WORDS];
    mem_addr_t   apb_ptr;       // Model of the window pointer

    sram_subsys_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // Expected word after an AHB write with lanes clipped at byte 3
    function automatic mem_word_t ahb_merge(input mem_word_t old, input mem_word_t data,
                                            input logic [1:0] off, input logic [2:0] size,
                                            input byte_en_t strb);
        mem_word_t   r;
        int unsigned last;
        r    = old;
        last = off + (1 << size) - 1;
        for (int b = 0; b < 4; b++)
        begin
            if (b >= off && b <= last && strb[b])
                r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t ns: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t ns: no response while waiting for %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic ahb_xfer(input logic write, input bus_addr_t a, input logic [2:0] size,
                            input mem_word_t data, input byte_en_t strb,
                            output mem_word_t rd);
        int n;
        @(posedge clk);
        hsel   <= 1'b1;
        htrans <= HTRANS_NONSEQ;
        haddr  <= a;
        hsize  <= size;
        hwrite <= write;
        @(posedge clk);
        hsel   <= 1'b0;         // Data phase with no next transfer
        htrans <= HTRANS_IDLE;
        hwdata <= data;
        hwstrb <= strb;
        n = 0;
        @(negedge clk);
        while (!hready_out)
        begin
            if (n == TIMEOUT)
                fail_timeout("AHB hready_out");
            n++;
            @(negedge clk);
        end
        rd = hrdata;
        check(hresp, 1'b0, "hresp on AHB response");
        if (write)
            ref_mem[a[MEM_AW+1:2]] = ahb_merge(ref_mem[a[MEM_AW+1:2]], data, a[1:0], size, strb);
    endtask

    task automatic ahb_check(input int w);
        mem_word_t rd;
        ahb_xfer(1'b0, bus_addr_t'(w * 4), HSIZE_WORD, '0, '0, rd);
        check(rd, ref_mem[w], $sformatf("AHB read of word %0d", w));
    endtask

    task automatic apb_xfer(input logic write, input apb_off_t off, input mem_word_t data,
                            output mem_word_t rd, output logic err);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= off;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready)
        begin
            if (n == TIMEOUT)
                fail_timeout("APB pready");
            n++;
            @(negedge clk);
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (off == APB_REG_ADDR && write)
            apb_ptr = data[MEM_AW-1:0];
        else if (off == APB_REG_DATA)
        begin
            if (write)
                ref_mem[apb_ptr] = data;    // Window always moves a full word
            apb_ptr = apb_ptr + 1'b1;
        end
    endtask

    initial
    begin
        mem_word_t  rd;
        mem_word_t  ahb_rd;
        mem_word_t  apb_rd;
        logic       err;
        logic [2:0] sz;
        lfsr    = 32'he4f2_b760;
        errors  = 0;
        checks  = 0;
        apb_ptr = '0;
        rst_n   = 1'b0;
        hsel    = 1'b0;
        hwrite  = 1'b0;
        hready  = 1'b1;
        haddr   = '0;
        htrans  = HTRANS_IDLE;
        hsize   = HSIZE_WORD;
        hwdata  = '0;
        hwstrb  = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = 'x;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(hready_out, 1'b1, "hready_out after reset");
        check(hresp, 1'b0, "hresp after reset");
        check(pready, 1'b0, "pready after reset");
        check(pslverr, 1'b0, "pslverr after reset");

        // Fill words 0..63 through the APB window
        apb_xfer(1'b1, APB_REG_ADDR, 32'd0, rd, err);
        for (int i = 0; i < 64; i++)
            apb_xfer(1'b1, APB_REG_DATA,
                     {8'ha5 ^ i[7:0], i[7:0], ~i[7:0], 8'h3c + i[7:0]}, rd, err);
        apb_xfer(1'b0, APB_REG_ADDR, '0, rd, err);
        check(rd, 32'd64, "APB pointer after window writes");
        for (int i = 0; i < 64; i++)
            ahb_check(i);

        // Random sized AHB writes over the filled words
        for (int i = 0; i < 40; i++)
        begin
            sz = 3'(rand_bits(2) % 3);
            ahb_xfer(1'b1, bus_addr_t'(rand_bits(8)), sz, rand_bits(32),
                     byte_en_t'(rand_bits(4)), rd);
        end
        for (int i = 0; i < 64; i++)
            ahb_check(i);

        // AHB writes read back through the window
        for (int i = 64; i < 72; i++)
            ahb_xfer(1'b1, bus_addr_t'(i * 4), HSIZE_WORD, rand_bits(32), 4'hf, rd);
        apb_xfer(1'b1, APB_REG_ADDR, 32'd64, rd, err);
        for (int i = 64; i < 72; i++)
        begin
            apb_xfer(1'b0, APB_REG_DATA, '0, rd, err);
            check(rd, ref_mem[i], $sformatf("APB window read of word %0d", i));
        end

        // Both ports at once with first requests in the same cycle
        apb_xfer(1'b1, APB_REG_ADDR, 32'd128, rd, err);
        fork
            for (int i = 96; i < 112; i++)
                ahb_xfer(1'b1, bus_addr_t'(i * 4), HSIZE_WORD, rand_bits(32), 4'hf, ahb_rd);
            for (int i = 128; i < 144; i++)
                apb_xfer(1'b1, APB_REG_DATA, rand_bits(32), apb_rd, err);
        join
        apb_xfer(1'b0, APB_REG_CONFLICT, '0, rd, err);
        check(rd != 32'd0, 1'b1, "CONFLICT count after colliding traffic");

        // Unmapped offsets with the window on a filled word
        apb_xfer(1'b1, APB_REG_ADDR, 32'd8, rd, err);
        apb_xfer(1'b1, 4'hc, 32'hdead_beef, rd, err);
        check(err, 1'b1, "pslverr on unmapped write");
        apb_xfer(1'b0, 4'hc, '0, rd, err);
        check(err, 1'b1, "pslverr on unmapped read");
        apb_xfer(1'b0, APB_REG_ADDR, '0, rd, err);
        check(rd, 32'd8, "APB pointer after unmapped accesses");
        for (int i = 0; i < 144; i++)
        begin
            if (!$isunknown(ref_mem[i]))
                ahb_check(i);
        end

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/sram_subsys_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_subsys_asserts (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     ahb_req,
    input wire                     ahb_we,
    input wire mem_pkg::byte_en_t  ahb_ben,
    input wire mem_pkg::mem_addr_t ahb_addr,
    input wire mem_pkg::mem_word_t ahb_wdata,
    input wire                     ahb_gnt,
    input wire                     apb_req,
    input wire                     apb_we,
    input wire mem_pkg::byte_en_t  apb_ben,
    input wire mem_pkg::mem_addr_t apb_addr,
    input wire mem_pkg::mem_word_t apb_wdata,
    input wire                     apb_gnt,
    input wire                     hresp,
    input wire                     psel,
    input wire                     penable,
    input wire                     pready
);

    // Bank has one port, one owner per cycle
    grant_excl: assert property (@(posedge clk) disable iff (!rst_n) !(ahb_gnt && apb_gnt))
        else $error("AHB and APB granted in the same cycle");

    hresp_okay: assert property (@(posedge clk) disable iff (!rst_n) !hresp)
        else $error("hresp left OKAY");

    // Lost arbitration keeps the request as it was
    ahb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ahb_req && !ahb_gnt |=> ahb_req && $stable(ahb_we) && $stable(ahb_ben)
                                && $stable(ahb_addr) && $stable(ahb_wdata))
        else $error("AHB request changed before grant");

    apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req && !apb_gnt |=> apb_req && $stable(apb_we) && $stable(apb_ben)
                                && $stable(apb_addr) && $stable(apb_wdata))
        else $error("APB request changed before grant");

    pready_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable)
        else $error("pready outside an APB access phase");

endmodule

bind sram_subsys_top sram_subsys_asserts i_asserts (.*);

`default_nettype wire

/* src/sram_subsys_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_subsys_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     hsel,
    input  wire mem_pkg::bus_addr_t haddr,
    input  wire [1:0]               htrans,
    input  wire [2:0]               hsize,
    input  wire                     hwrite,
    input  wire                     hready,
    input  wire mem_pkg::mem_word_t hwdata,
    input  wire mem_pkg::byte_en_t  hwstrb,
    output logic                    hready_out,
    output mem_pkg::mem_word_t      hrdata,
    output logic                    hresp,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire bus_pkg::apb_off_t  paddr,
    input  wire mem_pkg::mem_word_t pwdata,
    output mem_pkg::mem_word_t      prdata,
    output logic                    pready,
    output logic                    pslverr
);

    import mem_pkg::*;

    // AHB port to arbiter
    logic      ahb_req;
    logic      ahb_we;
    byte_en_t  ahb_ben;
    mem_addr_t ahb_addr;
    mem_word_t ahb_wdata;
    logic      ahb_gnt;

    // APB port to arbiter
    logic      apb_req;
    logic      apb_we;
    byte_en_t  apb_ben;
    mem_addr_t apb_addr;
    mem_word_t apb_wdata;
    logic      apb_gnt;

    // Bank side
    logic      mem_en;
    byte_en_t  mem_wen;
    mem_addr_t mem_addr;
    mem_word_t mem_din;
    mem_word_t mem_rdata;   // Shared by both ports

    ahb_sram_port i_ahb_port (
        .clk(clk), .rst_n(rst_n),
        .hsel(hsel), .hwrite(hwrite), .hready(hready), .haddr(haddr),
        .htrans(htrans), .hsize(hsize), .hwdata(hwdata), .hwstrb(hwstrb),
        .hready_out(hready_out), .hrdata(hrdata), .hresp(hresp),
        .req(ahb_req), .we(ahb_we), .ben(ahb_ben), .addr(ahb_addr),
        .wdata(ahb_wdata), .gnt(ahb_gnt), .rdata(mem_rdata)
    );

    apb_mem_port i_apb_port (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .req(apb_req), .we(apb_we), .ben(apb_ben), .addr(apb_addr),
        .wdata(apb_wdata), .gnt(apb_gnt), .rdata(mem_rdata)
    );

    mem_arbiter i_arb (
        .clk(clk), .rst_n(rst_n),
        .ahb_req(ahb_req), .ahb_we(ahb_we), .ahb_ben(ahb_ben),
        .ahb_addr(ahb_addr), .ahb_wdata(ahb_wdata),
        .apb_req(apb_req), .apb_we(apb_we), .apb_ben(apb_ben),
        .apb_addr(apb_addr), .apb_wdata(apb_wdata),
        .ahb_gnt(ahb_gnt), .apb_gnt(apb_gnt),
        .mem_en(mem_en), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_din(mem_din)
    );

    sram_bank i_bank (
        .clk(clk), .en(mem_en), .wen(mem_wen), .addr(mem_addr),
        .din(mem_din), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

/* src/apb_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_mem_port (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire bus_pkg::apb_off_t  paddr,
    input  wire mem_pkg::mem_word_t pwdata,
    output mem_pkg::mem_word_t      prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    req,
    output logic                    we,
    output mem_pkg::byte_en_t       ben,
    output mem_pkg::mem_addr_t      addr,
    output mem_pkg::mem_word_t      wdata,
    input  wire                     gnt,
    input  wire mem_pkg::mem_word_t rdata
);

    import mem_pkg::*;
    import bus_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_RD_WAIT
    } apb_state_t;

    apb_state_t  state;
    logic        access;
    logic        sel_addr;
    logic        sel_data;
    logic        sel_conf;
    logic        rd_done;
    logic [1:0]  rd_cnt;
    mem_addr_t   ptr;           // Window pointer
    logic [15:0] conflict_cnt;

    assign access   = psel & penable;
    assign sel_addr = (paddr == APB_REG_ADDR);
    assign sel_data = (paddr == APB_REG_DATA);
    assign sel_conf = (paddr == APB_REG_CONFLICT);
    assign rd_done  = (state == ST_RD_WAIT) && (rd_cnt == 2'(SRAM_READ_LATENCY));

    // Window access always moves a full word
    assign req   = access & sel_data & (state == ST_IDLE);
    assign we    = pwrite;
    assign ben   = pwrite ? '1 : '0;
    assign addr  = ptr;
    assign wdata = pwdata;

    // Register accesses and errors finish at once
    assign pready  = access & (~sel_data | (req & gnt & pwrite) | rd_done);
    assign pslverr = access & ~(sel_addr | sel_data | sel_conf);

    always_comb
    begin
        prdata = '0;
        if (sel_addr)
            prdata = mem_word_t'(ptr);
        else if (sel_data)
            prdata = rdata;
        else if (sel_conf)
            prdata = mem_word_t'(conflict_cnt);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            rd_cnt       <= '0;
            ptr          <= '0;
            conflict_cnt <= '0;
        end
        else
        begin
            if (access && sel_addr && pwrite)
                ptr <= pwdata[MEM_AW-1:0];
            else if (req && gnt)
                ptr <= ptr + 1'b1;  // Step after each window access

            if (req && !gnt)
                conflict_cnt <= conflict_cnt + 16'd1;

            if (req && gnt && !pwrite)
            begin
                state  <= ST_RD_WAIT;
                rd_cnt <= 2'd1;
            end
            else if (rd_done)
                state <= ST_IDLE;
            else if (state == ST_RD_WAIT)
                rd_cnt <= rd_cnt + 2'd1;
        end
    end

endmodule

`default_nettype wire

/* src/ahb_sram_port.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_sram_port (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     hsel,
    input  wire                     hwrite,
    input  wire                     hready,
    input  wire mem_pkg::bus_addr_t haddr,
    input  wire [1:0]               htrans,
    input  wire [2:0]               hsize,
    input  wire mem_pkg::mem_word_t hwdata,
    input  wire mem_pkg::byte_en_t  hwstrb,
    output logic                    hready_out,
    output mem_pkg::mem_word_t      hrdata,
    output logic                    hresp,
    output logic                    req,
    output logic                    we,
    output mem_pkg::byte_en_t       ben,
    output mem_pkg::mem_addr_t      addr,
    output mem_pkg::mem_word_t      wdata,
    input  wire                     gnt,
    input  wire mem_pkg::mem_word_t rdata
);

    import mem_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RD_WAIT
    } ahb_state_t;

    ahb_state_t state;
    ahb_state_t state_nxt;
    logic       trans_start;
    logic       we_q;       // Direction of the data phase
    byte_en_t   lane_dec;
    byte_en_t   lane_q;
    mem_addr_t  addr_q;
    logic [1:0] rd_cnt;     // Cycles since the read grant
    logic       rd_done;
    logic       xfer_done;

    assign trans_start = hsel & hready & (htrans inside {HTRANS_NONSEQ, HTRANS_SEQ});

    // Lanes from start byte upwards, clipped at byte 3
    always_comb
    begin
        case (hsize)
            HSIZE_BYTE: lane_dec = byte_en_t'(4'b0001 << haddr[1:0]);
            HSIZE_HALF: lane_dec = byte_en_t'(4'b0011 << haddr[1:0]);
            HSIZE_WORD: lane_dec = byte_en_t'(4'b1111 << haddr[1:0]);
            default:    lane_dec = '0;
        endcase
    end

    // Address phase capture
    always_ff @(posedge clk)
    begin
        if (trans_start)
        begin
            addr_q <= haddr[MEM_AW+1:2];
            lane_q <= lane_dec;
        end
    end

    assign rd_done   = (state == ST_RD_WAIT) && (rd_cnt == 2'(SRAM_READ_LATENCY));
    assign xfer_done = ((state == ST_REQ) && gnt && we_q) || rd_done;

    always_comb
    begin
        state_nxt = state;
        if ((state == ST_IDLE) || xfer_done)
            state_nxt = trans_start ? ST_REQ : ST_IDLE; // Pipelined next transfer
        else if ((state == ST_REQ) && gnt)
            state_nxt = ST_RD_WAIT;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= ST_IDLE;
            we_q   <= 1'b0;
            rd_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (trans_start)
                we_q <= hwrite;
            if ((state == ST_REQ) && gnt)
                rd_cnt <= 2'd1;
            else if ((state == ST_RD_WAIT) && !rd_done)
                rd_cnt <= rd_cnt + 2'd1;
        end
    end

    // Bank request, held until granted
    assign req   = (state == ST_REQ);
    assign we    = we_q;
    assign ben   = we_q ? (lane_q & hwstrb) : '0;
    assign addr  = addr_q;
    assign wdata = hwdata;

    assign hready_out = (state == ST_IDLE) | xfer_done;
    assign hrdata     = rdata;  // Valid when rd_done
    assign hresp      = 1'b0;   // Always OKAY

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ahb_req,
    input  wire                     ahb_we,
    input  wire mem_pkg::byte_en_t  ahb_ben,
    input  wire mem_pkg::mem_addr_t ahb_addr,
    input  wire mem_pkg::mem_word_t ahb_wdata,
    input  wire                     apb_req,
    input  wire                     apb_we,
    input  wire mem_pkg::byte_en_t  apb_ben,
    input  wire mem_pkg::mem_addr_t apb_addr,
    input  wire mem_pkg::mem_word_t apb_wdata,
    output logic                    ahb_gnt,
    output logic                    apb_gnt,
    output logic                    mem_en,
    output mem_pkg::byte_en_t       mem_wen,
    output mem_pkg::mem_addr_t      mem_addr,
    output mem_pkg::mem_word_t      mem_din
);

    import mem_pkg::*;

    logic conflict;
    logic last_apb; // APB won the previous conflict

    assign conflict = ahb_req & apb_req;

    // Loser of the last conflict goes first
    assign ahb_gnt = ahb_req & (~apb_req | last_apb);
    assign apb_gnt = apb_req & (~ahb_req | ~last_apb);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            last_apb <= 1'b0;
        else if (conflict)
            last_apb <= apb_gnt;
    end

    assign mem_en = ahb_gnt | apb_gnt;

    always_comb
    begin
        mem_wen  = '0;
        mem_addr = apb_addr;
        mem_din  = apb_wdata;
        if (ahb_gnt)
        begin
            mem_wen  = ahb_we ? ahb_ben : '0;
            mem_addr = ahb_addr;
            mem_din  = ahb_wdata;
        end
        else if (apb_gnt)
            mem_wen = apb_we ? apb_ben : '0; // Reads keep lanes off
    end

endmodule

`default_nettype wire

/* src/sram_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_bank (
    input  wire                 clk,
    input  wire                 en,
    input  wire mem_pkg::byte_en_t  wen,
    input  wire mem_pkg::mem_addr_t addr,
    input  wire mem_pkg::mem_word_t din,
    output mem_pkg::mem_word_t      rdata
);

    import mem_pkg::*;

    localparam int unsigned LANES = $bits(byte_en_t);

    mem_word_t mem [MEM_WORDS];
    mem_word_t rd_pipe [SRAM_READ_LATENCY]; // Read data stages

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (wen[i])
                    mem[addr][8*i +: 8] <= din[8*i +: 8];
            end
            // No lane enabled means a read
            if (wen == '0)
                rd_pipe[0] <= mem[addr];
        end

        // Later stages shift every cycle so reads can overlap
        for (int s = 1; s < SRAM_READ_LATENCY; s++)
        begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    assign rdata = rd_pipe[SRAM_READ_LATENCY-1];

endmodule

`default_nettype wire

/* src/bus_pkg.sv */
`default_nettype none

// AHB transfer encodings and the APB register map
package bus_pkg;

    // HTRANS
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // HSIZE, only up to one word is served
    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Register offset on the housekeeping port
    typedef logic [3:0] apb_off_t;

    // Word pointer into the bank
    localparam apb_off_t APB_REG_ADDR = 4'h0;

    // Data window, steps the pointer on every access
    localparam apb_off_t APB_REG_DATA = 4'h4;

    // Lost arbitration cycles, read only
    localparam apb_off_t APB_REG_CONFLICT = 4'h8;

endpackage

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

// Geometry and data types of the shared SRAM bank
package mem_pkg;

    // Bank size in 32-bit words
    localparam int unsigned MEM_WORDS = 256;

    // Word address width, log2 of MEM_WORDS
    localparam int unsigned MEM_AW = 8;

    // Cycles from a granted read to valid rdata (1 or 2)
    localparam int unsigned SRAM_READ_LATENCY = 1;

    // One bank word
    typedef logic [31:0] mem_word_t;

    // Word index into the bank
    typedef logic [MEM_AW-1:0] mem_addr_t;

    // Per byte lane write enables, bit 0 is the low byte
    typedef logic [3:0] byte_en_t;

    // Byte address as seen on the AHB side
    typedef logic [31:0] bus_addr_t;

endpackage

`default_nettype wire
